// ==== bench/mdu_asserts.sv ====
/*
 * Timing checks of the multiply-divide unit, bound into mdu_top.
 * Assumes both units use the same cycle count.
 * fail_cnt counts failed checks so the testbench can see them.
 */

`include "mdu_params.svh"

module mdu_asserts (
        input logic                     clk,
        input logic                     rst,
        input logic                     issue,
        input logic                     ready,
        input logic                     result_valid,
        input logic [`MDU_XLEN-1:0]     result
);

        timeunit 1ns;
        timeprecision 1ps;

        localparam int result_delay = `MDU_MUL_CYCLES + 1;

        int unsigned fail_cnt = 0;

        // a taken operation makes the unit busy at once.
        ready_low_after_issue: assert property (
                @(posedge clk) disable iff (rst) issue |=> !ready
        ) else begin
                $error("ready stayed high in the cycle after an issue");
                fail_cnt++;
        end

        valid_after_issue: assert property (
                @(posedge clk) disable iff (rst) issue |-> ##result_delay result_valid
        ) else begin
                $error("result_valid did not arrive %0d cycles after an issue", result_delay);
                fail_cnt++;
        end

        // no pulse without an issue at the right distance.
        valid_has_issue: assert property (
                @(posedge clk) disable iff (rst) result_valid |-> $past(issue, result_delay)
        ) else begin
                $error("result_valid without an issue %0d cycles earlier", result_delay);
                fail_cnt++;
        end

        valid_one_cycle: assert property (
                @(posedge clk) disable iff (rst) result_valid |=> !result_valid
        ) else begin
                $error("result_valid was high for more than one cycle");
                fail_cnt++;
        end

        result_holds: assert property (
                @(posedge clk) disable iff (rst) !result_valid |-> $stable(result)
        ) else begin
                $error("result changed while result_valid was low");
                fail_cnt++;
        end

        // first cycle out of reset.
        idle_after_reset: assert property (
                @(posedge clk) $fell(rst) |-> (ready && !result_valid)
        ) else begin
                $error("unit not idle in the first cycle after reset");
                fail_cnt++;
        end

endmodule

bind mdu_top mdu_asserts asserts_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .ready        (ready),
        .result_valid (result_valid),
        .result       (result)
);

// ==== bench/mdu_tb.sv ====
/*
 * Testbench of the multiply-divide unit.
 * Results are compared against a model built from the M extension rules.
 * Handshake timing is checked by the bound mdu_asserts.
 * Assumes MDU_XLEN is 64 and both unit cycle counts are equal.
 */

`include "mdu_params.svh"

module mdu_tb;

        timeunit 1ns;
        timeprecision 1ps;

        localparam int result_delay = `MDU_MUL_CYCLES + 1;
        localparam int wait_limit = 50;

        logic clk;
        logic rst;
        logic op_valid;
        mdu_pkg::mdu_op_e op;
        logic word;
        logic [`MDU_XLEN-1:0] src1;
        logic [`MDU_XLEN-1:0] src2;
        logic ready;
        logic result_valid;
        logic [`MDU_XLEN-1:0] result;

        // operations collected for the next batch.
        mdu_pkg::mdu_op_e q_op[$];
        logic q_word[$];
        logic [63:0] q_a[$];
        logic [63:0] q_b[$];

        logic [31:0] lcg_state = 32'hec48_925a;
        int tests_passed = 0;
        int tests_failed = 0;

        mdu_top dut_i (
                .clk          (clk),
                .rst          (rst),
                .op_valid     (op_valid),
                .op           (op),
                .word         (word),
                .src1         (src1),
                .src2         (src2),
                .ready        (ready),
                .result_valid (result_valid),
                .result       (result)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        function automatic logic [63:0] rand64();
                logic [31:0] hi;
                logic [31:0] lo;
                hi = lcg_next();
                lo = lcg_next();
                return {hi, lo};
        endfunction

        // random value shifted down, so quotients are not always zero.
        // about half of them are negated to reach negative divisors.
        function automatic logic [63:0] small_divisor();
                logic [63:0] r;
                logic [31:0] sh;
                r = rand64();
                sh = lcg_next();
                r = r >> sh[5:0];
                return sh[31] ? -r : r;
        endfunction

        function automatic logic [63:0] sext_word(logic [31:0] v);
                return {{32{v[31]}}, v};
        endfunction

        // quotient and remainder by magnitudes, then the signs are fixed up.
        function automatic logic [63:0] divide_model(mdu_pkg::mdu_op_e f, logic w,
                                                     logic [63:0] a, logic [63:0] b);
                logic sgn;
                logic rem;
                logic na;
                logic nb;
                logic [63:0] x;
                logic [63:0] y;
                logic [63:0] minv;
                logic [63:0] ma;
                logic [63:0] mb;
                logic [63:0] q;
                logic [63:0] r;
                logic [63:0] res;
                sgn = (f == mdu_pkg::op_div) || (f == mdu_pkg::op_rem);
                rem = (f == mdu_pkg::op_rem) || (f == mdu_pkg::op_remu);
                if (w) begin
                        x = sgn ? sext_word(a[31:0]) : {32'h0, a[31:0]};
                        y = sgn ? sext_word(b[31:0]) : {32'h0, b[31:0]};
                        minv = sext_word(32'h8000_0000);
                end else begin
                        x = a;
                        y = b;
                        minv = 64'h8000_0000_0000_0000;
                end
                if (y == 64'h0) begin
                        q = '1;
                        r = x;
                end else if (sgn && x == minv && y == '1) begin
                        q = x;
                        r = 64'h0;
                end else begin
                        na = sgn && x[63];
                        nb = sgn && y[63];
                        ma = na ? -x : x;
                        mb = nb ? -y : y;
                        q = ma / mb;
                        r = ma % mb;
                        if (na != nb) begin
                                q = -q;
                        end
                        if (na) begin
                                r = -r;
                        end
                end
                res = rem ? r : q;
                return w ? sext_word(res[31:0]) : res;
        endfunction

        function automatic logic [63:0] expected_result(mdu_pkg::mdu_op_e f, logic w,
                                                        logic [63:0] a, logic [63:0] b);
                logic [127:0] p;
                case (f)
                        mdu_pkg::op_mul: begin
                                p = {64'h0, a} * {64'h0, b};
                                return w ? sext_word(p[31:0]) : p[63:0];
                        end
                        mdu_pkg::op_mulh: begin
                                p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
                                return p[127:64];
                        end
                        mdu_pkg::op_mulhsu: begin
                                p = {{64{a[63]}}, a} * {64'h0, b};
                                return p[127:64];
                        end
                        mdu_pkg::op_mulhu: begin
                                p = {64'h0, a} * {64'h0, b};
                                return p[127:64];
                        end
                        default: return divide_model(f, w, a, b);
                endcase
        endfunction

        task automatic add_op(mdu_pkg::mdu_op_e f, logic w, logic [63:0] a, logic [63:0] b);
                q_op.push_back(f);
                q_word.push_back(w);
                q_a.push_back(a);
                q_b.push_back(b);
        endtask

        task automatic drive_op(int k);
                op_valid = 1'b1;
                op = q_op[k];
                word = q_word[k];
                src1 = q_a[k];
                src2 = q_b[k];
        endtask

        // operands are scrambled so a late sample would show up.
        task automatic drive_idle();
                op_valid = 1'b0;
                op = mdu_pkg::op_mul;
                word = 1'b0;
                src1 = rand64();
                src2 = rand64();
        endtask

        task automatic finish_test(string name, int n, int errs);
                $display("test %s: %0d checks, %0d errors", name, n, errs);
                if (errs == 0) begin
                        tests_passed++;
                end else begin
                        tests_failed++;
                end
        endtask

        // with hold set, op_valid stays high and the next op waits on the bus.
        task automatic run_batch(string name, bit hold);
                int n;
                int errs;
                int waited;
                logic [63:0] exp;
                n = q_op.size();
                errs = 0;
                for (int k = 0; k < n; k++) begin
                        waited = 0;
                        while (!ready && waited < wait_limit) begin
                                @(negedge clk);
                                waited++;
                        end
                        if (!ready) begin
                                $display("%s: ready never returned high for operation %0d",
                                         name, k);
                                errs++;
                                break;
                        end
                        if (!hold || k == 0) begin
                                drive_op(k);
                        end
                        @(posedge clk);
                        @(negedge clk);
                        if (hold && k + 1 < n) begin
                                drive_op(k + 1);
                        end else begin
                                drive_idle();
                        end
                        // one cycle has passed since the issue cycle.
                        waited = 1;
                        while (!result_valid && waited < wait_limit) begin
                                @(negedge clk);
                                waited++;
                        end
                        if (!result_valid) begin
                                $display("%s: no result arrived for operation %0d", name, k);
                                errs++;
                                break;
                        end
                        assert (waited == result_delay) else begin
                                $display("FAILED %s op %0d latency expected %0d actual %0d",
                                         name, k, result_delay, waited);
                                errs++;
                        end
                        exp = expected_result(q_op[k], q_word[k], q_a[k], q_b[k]);
                        assert (result === exp) else begin
                                $display("FAILED %s op %0d (%s word=%b) expected %h actual %h",
                                         name, k, q_op[k].name(), q_word[k], exp, result);
                                errs++;
                        end
                end
                drive_idle();
                finish_test(name, n, errs);
                q_op.delete();
                q_word.delete();
                q_a.delete();
                q_b.delete();
        endtask

        initial begin
                logic [63:0] edges [5];
                mdu_pkg::mdu_op_e f;
                logic [63:0] a;
                logic [63:0] b;
                int errs;
                edges = '{64'h0, 64'h1, 64'hffff_ffff_ffff_ffff,
                          64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff};
                rst = 1'b1;
                op_valid = 1'b0;
                op = mdu_pkg::op_mul;
                word = 1'b0;
                src1 = '0;
                src2 = '0;
                repeat (10) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;

                errs = 0;
                repeat (8) begin
                        assert (ready === 1'b1 && result_valid === 1'b0) else begin
                                $display("FAILED idle_after_reset expected ready=1 valid=0 %s",
                                         $sformatf("actual ready=%b valid=%b",
                                                   ready, result_valid));
                                errs++;
                        end
                        @(negedge clk);
                end
                finish_test("idle_after_reset", 8, errs);

                // the fifth form is MULW.
                for (int i = 0; i < 5; i++) begin
                        f = (i < 4) ? mdu_pkg::mdu_op_e'(3'(i)) : mdu_pkg::op_mul;
                        for (int x = 0; x < 5; x++) begin
                                for (int y = 0; y < 5; y++) begin
                                        add_op(f, i == 4, edges[x], edges[y]);
                                end
                        end
                        repeat (6) add_op(f, i == 4, rand64(), rand64());
                end
                run_batch("multiply", 1'b0);

                for (int i = 4; i < 8; i++) begin
                        f = mdu_pkg::mdu_op_e'(3'(i));
                        repeat (6) begin
                                add_op(f, 1'b0, rand64(), small_divisor());
                                add_op(f, 1'b1, rand64(), small_divisor());
                        end
                end
                run_batch("divide", 1'b0);

                // word forms get junk in the upper halves.
                for (int i = 4; i < 8; i++) begin
                        f = mdu_pkg::mdu_op_e'(3'(i));
                        add_op(f, 1'b0, rand64(), 64'h0);
                        add_op(f, 1'b1, rand64(), {lcg_next(), 32'h0});
                        add_op(f, 1'b0, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff);
                        add_op(f, 1'b1, {lcg_next(), 32'h8000_0000}, {lcg_next(), 32'hffff_ffff});
                end
                run_batch("divide_corners", 1'b0);

                for (int k = 0; k < 12; k++) begin
                        a = rand64();
                        f = mdu_pkg::mdu_op_e'({k[0], a[1:0]});
                        add_op(f, a[2], rand64(), small_divisor());
                end
                run_batch("back_to_back", 1'b1);

                for (int i = 1; i < 4; i++) begin
                        f = mdu_pkg::mdu_op_e'(3'(i));
                        repeat (3) begin
                                a = rand64();
                                b = rand64();
                                add_op(f, 1'b1, a, b);
                                add_op(f, 1'b0, a, b);
                        end
                end
                run_batch("high_word_flag", 1'b0);

                finish_test("timing_checks", 1, dut_i.asserts_i.fail_cnt);

                $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
                if (tests_failed == 0) begin
                        $display("All tests passed");
                end else begin
                        $display("Some tests failed");
                end
                $finish;
        end

endmodule

// ==== build.f ====
+incdir+src
src/mdu_pkg.sv
src/mdu_mul.sv
src/mdu_div.sv
src/mdu_combine.sv
src/mdu_top.sv
bench/mdu_asserts.sv
bench/mdu_tb.sv

// ==== src/mdu_combine.sv ====
/*
 * Issue control and result register of the multiply-divide unit.
 * Only one operation is in flight, so the two done pulses never overlap.
 * result holds its value until the next result_valid pulse.
 */

`include "mdu_params.svh"

module mdu_combine (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    op_valid,
        input  logic                    mul_idle,
        input  logic                    mul_done,
        input  logic                    div_idle,
        input  logic                    div_done,
        input  logic [`MDU_XLEN-1:0]    mul_result,
        input  logic [`MDU_XLEN-1:0]    div_result,
        output logic                    ready,
        output logic                    issue,
        output logic                    result_valid,
        output logic [`MDU_XLEN-1:0]    result
);

        // a new operation waits until both units are idle.
        assign ready = mul_idle & div_idle;
        assign issue = op_valid & ready;

        // one-cycle pulse, one cycle after the unit's done.
        always_ff @(posedge clk) begin
                if (rst) begin
                        result_valid <= 1'b0;
                end else begin
                        result_valid <= mul_done | div_done;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        result <= '0;
                end else if (mul_done) begin
                        result <= mul_result;
                end else if (div_done) begin
                        result <= div_result;
                end
        end

endmodule

// ==== src/mdu_div.sv ====
/*
 * Multi-cycle divider for DIV, DIVU, REM, REMU and their word forms.
 * Starts only on an issue of a divide or remainder operation.
 * Divide by zero and signed overflow give the RISC-V values, never X.
 * quotient_or_rem is valid while done is high.
 */

`include "mdu_params.svh"

module mdu_div (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    issue,
        input  mdu_pkg::mdu_op_e        op,
        input  logic                    word,
        input  logic [`MDU_XLEN-1:0]    src1,
        input  logic [`MDU_XLEN-1:0]    src2,
        output logic                    idle,
        output logic                    done,
        output logic [`MDU_XLEN-1:0]    quotient_or_rem
);

        localparam int cnt_w = $clog2(`MDU_DIV_CYCLES + 1);
        localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`MDU_DIV_CYCLES - 1);

        mdu_pkg::unit_state_e state;
        mdu_pkg::unit_state_e next_state;
        logic [cnt_w-1:0] cnt;
        logic start;

        mdu_pkg::mdu_op_e op_q;
        logic word_q;
        logic [`MDU_XLEN-1:0] a_q;
        logic [`MDU_XLEN-1:0] b_q;

        logic is_signed;
        logic is_rem;
        logic zero_d;
        logic zero_w;
        logic ovf_d;
        logic ovf_w;
        logic [`MDU_XLEN-1:0] b_d;
        logic [31:0] b_w;
        logic [`MDU_XLEN-1:0] q_d;
        logic [`MDU_XLEN-1:0] r_d;
        logic [31:0] q_w;
        logic [31:0] r_w;
        logic [`MDU_XLEN-1:0] res_d;
        logic [31:0] res_w;

        assign start = issue && (op inside {mdu_pkg::op_div, mdu_pkg::op_divu,
                                            mdu_pkg::op_rem, mdu_pkg::op_remu});

        assign idle = (state == mdu_pkg::st_idle);
        assign done = (state == mdu_pkg::st_busy) && (cnt == last_cnt);

        always_comb begin
                next_state = state;
                case (state)
                        mdu_pkg::st_idle: begin
                                if (start) begin
                                        next_state = mdu_pkg::st_busy;
                                end
                        end
                        mdu_pkg::st_busy: begin
                                if (cnt == last_cnt) begin
                                        next_state = mdu_pkg::st_idle;
                                end
                        end
                        default: next_state = mdu_pkg::st_idle;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= mdu_pkg::st_idle;
                end else begin
                        state <= next_state;
                end
        end

        always_ff @(posedge clk) begin
                if (rst || start) begin
                        cnt <= '0;
                end else if (state == mdu_pkg::st_busy) begin
                        cnt <= cnt + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (start) begin
                        op_q   <= op;
                        word_q <= word;
                        a_q    <= src1;
                        b_q    <= src2;
                end
        end

        assign is_signed = (op_q == mdu_pkg::op_div) || (op_q == mdu_pkg::op_rem);
        assign is_rem    = (op_q == mdu_pkg::op_rem) || (op_q == mdu_pkg::op_remu);

        assign zero_d = (b_q == '0);
        assign zero_w = (b_q[31:0] == 32'h0);
        assign ovf_d  = is_signed && (a_q == {1'b1, {(`MDU_XLEN-1){1'b0}}}) && (&b_q);
        assign ovf_w  = is_signed && (a_q[31:0] == 32'h8000_0000) && (&b_q[31:0]);

        // a divisor of one on overflow yields dividend and zero directly;
        // on divide by zero it only keeps the operator away from X.
        assign b_d = (zero_d || ovf_d) ? `MDU_XLEN'(1) : b_q;
        assign b_w = (zero_w || ovf_w) ? 32'd1 : b_q[31:0];

        always_comb begin
                if (is_signed) begin
                        q_d = $signed(a_q) / $signed(b_d);
                        r_d = $signed(a_q) % $signed(b_d);
                        q_w = $signed(a_q[31:0]) / $signed(b_w);
                        r_w = $signed(a_q[31:0]) % $signed(b_w);
                end else begin
                        q_d = a_q / b_d;
                        r_d = a_q % b_d;
                        q_w = a_q[31:0] / b_w;
                        r_w = a_q[31:0] % b_w;
                end
        end

        // divide by zero: all-ones quotient, remainder is the dividend.
        assign res_d = is_rem ? (zero_d ? a_q : r_d) : (zero_d ? '1 : q_d);
        assign res_w = is_rem ? (zero_w ? a_q[31:0] : r_w) : (zero_w ? 32'hffff_ffff : q_w);

        assign quotient_or_rem = word_q ? {{(`MDU_XLEN-32){res_w[31]}}, res_w} : res_d;

endmodule

// ==== src/mdu_mul.sv ====
/*
 * Multi-cycle multiplier for MUL, MULH, MULHSU, MULHU and MULW.
 * Starts only on an issue of a multiply operation.
 * product is valid while done is high and holds until the next start.
 * The word flag only affects MUL; high-half multiplies ignore it.
 */

`include "mdu_params.svh"

module mdu_mul (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    issue,
        input  mdu_pkg::mdu_op_e        op,
        input  logic                    word,
        input  logic [`MDU_XLEN-1:0]    src1,
        input  logic [`MDU_XLEN-1:0]    src2,
        output logic                    idle,
        output logic                    done,
        output logic [`MDU_XLEN-1:0]    product
);

        localparam int cnt_w = $clog2(`MDU_MUL_CYCLES + 1);
        localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`MDU_MUL_CYCLES - 1);

        mdu_pkg::unit_state_e state;
        mdu_pkg::unit_state_e next_state;
        logic [cnt_w-1:0] cnt;
        logic start;

        mdu_pkg::mdu_op_e op_q;
        logic word_q;
        logic [`MDU_XLEN-1:0] a_q;
        logic [`MDU_XLEN-1:0] b_q;

        logic a_sgn;
        logic b_sgn;
        logic signed [`MDU_XLEN:0] a_ext;
        logic signed [`MDU_XLEN:0] b_ext;
        logic signed [2*`MDU_XLEN+1:0] prod_full;

        // only the multiply half of the opcode space belongs here.
        assign start = issue && (op inside {mdu_pkg::op_mul, mdu_pkg::op_mulh,
                                            mdu_pkg::op_mulhsu, mdu_pkg::op_mulhu});

        assign idle = (state == mdu_pkg::st_idle);
        assign done = (state == mdu_pkg::st_busy) && (cnt == last_cnt);

        always_comb begin
                next_state = state;
                case (state)
                        mdu_pkg::st_idle: begin
                                if (start) begin
                                        next_state = mdu_pkg::st_busy;
                                end
                        end
                        mdu_pkg::st_busy: begin
                                if (cnt == last_cnt) begin
                                        next_state = mdu_pkg::st_idle;
                                end
                        end
                        default: next_state = mdu_pkg::st_idle;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= mdu_pkg::st_idle;
                end else begin
                        state <= next_state;
                end
        end

        // counts the busy cycles; done marks the last one.
        always_ff @(posedge clk) begin
                if (rst || start) begin
                        cnt <= '0;
                end else if (state == mdu_pkg::st_busy) begin
                        cnt <= cnt + 1'b1;
                end
        end

        // operands are captured on the issue edge.
        always_ff @(posedge clk) begin
                if (start) begin
                        op_q   <= op;
                        word_q <= word;
                        a_q    <= src1;
                        b_q    <= src2;
                end
        end

        // one extra bit per operand covers signed, unsigned and mixed forms.
        assign a_sgn = (op_q == mdu_pkg::op_mulh) || (op_q == mdu_pkg::op_mulhsu);
        assign b_sgn = (op_q == mdu_pkg::op_mulh);
        assign a_ext = {a_sgn & a_q[`MDU_XLEN-1], a_q};
        assign b_ext = {b_sgn & b_q[`MDU_XLEN-1], b_q};
        assign prod_full = a_ext * b_ext;

        always_comb begin
                case (op_q)
                        mdu_pkg::op_mul: begin
                                if (word_q) begin
                                        // low 32 bits do not depend on the upper operand bits.
                                        product = {{(`MDU_XLEN-32){prod_full[31]}},
                                                   prod_full[31:0]};
                                end else begin
                                        product = prod_full[`MDU_XLEN-1:0];
                                end
                        end
                        default: product = prod_full[2*`MDU_XLEN-1:`MDU_XLEN];
                endcase
        end

endmodule

// ==== src/mdu_params.svh ====
/*
 * Width and timing constants of the multiply-divide unit.
 * MDU_XLEN must stay 64; the word forms assume a 32-bit low half.
 * Both cycle counts must be at least 1.
 */

`ifndef MDU_PARAMS_SVH
`define MDU_PARAMS_SVH

// data path width of the operands and the result.
`define MDU_XLEN 64

// cycles the multiplier stays busy after it accepts an operation.
`define MDU_MUL_CYCLES 4

// cycles the divider stays busy after it accepts an operation.
`define MDU_DIV_CYCLES 4

`endif

// ==== src/mdu_pkg.sv ====
/*
 * Types shared by the multiply-divide unit and its testbench.
 * The operation encoding follows funct3 of the RISC-V M extension,
 * so op[2] alone separates multiplies from divides.
 */

package mdu_pkg;

        // the eight M extension operations.
        // the word form is carried on a separate flag, not in this encoding.
        typedef enum logic [2:0] {
                op_mul    = 3'd0,
                op_mulh   = 3'd1,
                op_mulhsu = 3'd2,
                op_mulhu  = 3'd3,
                op_div    = 3'd4,
                op_divu   = 3'd5,
                op_rem    = 3'd6,
                op_remu   = 3'd7
        } mdu_op_e;

        // state of one multi-cycle unit.
        typedef enum logic {
                st_idle = 1'b0,
                st_busy = 1'b1
        } unit_state_e;

endpackage

// ==== src/mdu_top.sv ====
/*
 * RV64 M extension multiply-divide unit.
 * Issue when op_valid and ready are both high; operands need only be
 * stable in that cycle. result_valid pulses MDU_*_CYCLES + 1 cycles later.
 * No pipelining, no flush, no illegal-op detection.
 */

`include "mdu_params.svh"

module mdu_top (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    op_valid,
        input  mdu_pkg::mdu_op_e        op,
        input  logic                    word,
        input  logic [`MDU_XLEN-1:0]    src1,
        input  logic [`MDU_XLEN-1:0]    src2,
        output logic                    ready,
        output logic                    result_valid,
        output logic [`MDU_XLEN-1:0]    result
);

        logic issue;
        logic mul_idle;
        logic mul_done;
        logic div_idle;
        logic div_done;
        logic [`MDU_XLEN-1:0] mul_result;
        logic [`MDU_XLEN-1:0] div_result;

        // both units see every issue and pick their own class of op.
        mdu_mul mul_i (
                .clk     (clk),
                .rst     (rst),
                .issue   (issue),
                .op      (op),
                .word    (word),
                .src1    (src1),
                .src2    (src2),
                .idle    (mul_idle),
                .done    (mul_done),
                .product (mul_result)
        );

        mdu_div div_i (
                .clk             (clk),
                .rst             (rst),
                .issue           (issue),
                .op              (op),
                .word            (word),
                .src1            (src1),
                .src2            (src2),
                .idle            (div_idle),
                .done            (div_done),
                .quotient_or_rem (div_result)
        );

        mdu_combine combine_i (
                .clk          (clk),
                .rst          (rst),
                .op_valid     (op_valid),
                .mul_idle     (mul_idle),
                .mul_done     (mul_done),
                .div_idle     (div_idle),
                .div_done     (div_done),
                .mul_result   (mul_result),
                .div_result   (div_result),
                .ready        (ready),
                .issue        (issue),
                .result_valid (result_valid),
                .result       (result)
        );

endmodule
